// ==== design/calc_pkg.sv ====
/*
 * Calculator package
 * Widths, completion stage indices, opcode and operation encodings and
 * the two views of an instruction word
 */
package calc_pkg;

  // Datapath widths
  localparam int DWORD_W    = 64;
  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OP_W       = 3;

  // Internal operation codes
  localparam logic [OP_W-1:0] OP_ADD = 3'd0;
  localparam logic [OP_W-1:0] OP_SUB = 3'd1;
  localparam logic [OP_W-1:0] OP_AND = 3'd2;
  localparam logic [OP_W-1:0] OP_OR  = 3'd3;
  localparam logic [OP_W-1:0] OP_XOR = 3'd4;
  localparam logic [OP_W-1:0] OP_MUL = 3'd5;

  // RV64 major opcodes
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  // M extension selector in funct7
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Completion pipe stage indices
  localparam int ALU_STAGE    = 1;
  localparam int MUL_STAGE    = 2;
  localparam int COMMIT_STAGE = 2;
  // Last stage, also the pipe depth
  localparam int WB_STAGE     = 3;

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } rv_instr_u;

endpackage

// ==== design/issue_if.sv ====
/*
 * Issued operation bus
 * Carries the reservation register to the execution pipes and the
 * completion pipe
 */
`timescale 1ns/1ps

interface issue_if;
  import calc_pkg::*;

  // Issued and not poisoned
  logic                  v;
  logic [OP_W-1:0]       op;
  // Bypassed operands
  logic [DWORD_W-1:0]    opnd_a;
  // Immediate for I-type forms
  logic [DWORD_W-1:0]    opnd_b;
  logic [REG_ADDR_W-1:0] rd_addr;
  // Writes a register other than x0
  logic                  wr_v;

  modport producer (
    output v, op, opnd_a, opnd_b, rd_addr, wr_v
  );

  modport consumer (
    input  v, op, opnd_a, opnd_b, rd_addr, wr_v
  );

endinterface

// ==== design/issue_stage.sv ====
/*
 * Issue stage
 * Decodes the dispatched instruction, corrects its operands from the
 * in-flight results and loads the reservation register
 */
`timescale 1ns/1ps

module issue_stage (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic                                               dispatch_v_i,
  input  logic [calc_pkg::INSTR_W-1:0]                       instr_i,
  input  logic [calc_pkg::DWORD_W-1:0]                       rs1_i,
  input  logic [calc_pkg::DWORD_W-1:0]                       rs2_i,
  input  logic                                               flush_i,
  input  logic [calc_pkg::WB_STAGE:1]                        fwd_v_i,
  input  logic [calc_pkg::WB_STAGE:1][calc_pkg::REG_ADDR_W-1:0] fwd_rd_addr_i,
  input  logic [calc_pkg::WB_STAGE:1][calc_pkg::DWORD_W-1:0]    fwd_data_i,
  issue_if.producer                                          issue_o,
  output logic [calc_pkg::INSTR_W-1:0]                       issue_instr_o
);
  import calc_pkg::*;

  rv_instr_u          instr;
  logic [OP_W-1:0]    op_n;
  logic               dec_wr_v;
  logic               use_imm;
  logic [DWORD_W-1:0] imm_sext;
  logic [DWORD_W-1:0] opnd_a_n;
  logic [DWORD_W-1:0] opnd_b_n;

  // Youngest matching tap wins, x0 is hardwired
  function automatic logic [DWORD_W-1:0] bypass_f(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [DWORD_W-1:0]    reg_data
  );
    logic [DWORD_W-1:0] result;
    result = reg_data;
    for (int i = WB_STAGE; i >= 1; i--)
    begin
      if (fwd_v_i[i] && (fwd_rd_addr_i[i] == addr))
      begin
        result = fwd_data_i[i];
      end
    end
    if (addr == '0)
    begin
      result = '0;
    end
    return result;
  endfunction

  assign instr    = instr_i;
  assign imm_sext = {{(DWORD_W-12){instr.i.imm[11]}}, instr.i.imm};

  always_comb
  begin
    op_n     = OP_ADD;
    dec_wr_v = 1'b0;
    use_imm  = 1'b0;
    case (instr.r.opcode)
      OPC_OP:
      begin
        dec_wr_v = 1'b1;
        // funct7 and funct3 together select the R-type operation
        case ({instr.r.funct7, instr.r.funct3})
          {FUNCT7_MULDIV, 3'b000}: op_n = OP_MUL;
          10'b0000000_000:         op_n = OP_ADD;
          10'b0100000_000:         op_n = OP_SUB;
          10'b0000000_100:         op_n = OP_XOR;
          10'b0000000_110:         op_n = OP_OR;
          10'b0000000_111:         op_n = OP_AND;
          default:                 dec_wr_v = 1'b0;
        endcase
      end
      OPC_OP_IMM:
      begin
        use_imm  = 1'b1;
        dec_wr_v = 1'b1;
        case (instr.i.funct3)
          3'b000:  op_n = OP_ADD;
          3'b100:  op_n = OP_XOR;
          3'b110:  op_n = OP_OR;
          3'b111:  op_n = OP_AND;
          // Shifts and compares are not supported
          default: dec_wr_v = 1'b0;
        endcase
      end
      default:
      begin
        dec_wr_v = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    opnd_a_n = bypass_f(instr.r.rs1, rs1_i);
    opnd_b_n = use_imm ? imm_sext : bypass_f(instr.r.rs2, rs2_i);
  end

  // Reservation register
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      issue_o.v <= 1'b0;
    end
    else
    begin
      issue_o.v <= dispatch_v_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    issue_o.op      <= op_n;
    issue_o.opnd_a  <= opnd_a_n;
    issue_o.opnd_b  <= opnd_b_n;
    issue_o.rd_addr <= instr.r.rd;
    issue_o.wr_v    <= dec_wr_v & (instr.r.rd != '0);
    issue_instr_o   <= instr_i;
  end

endmodule

// ==== design/int_alu_pipe.sv ====
/*
 * Integer ALU pipe
 * Single-cycle logic and add/subtract on the issued operands
 */
`timescale 1ns/1ps

module int_alu_pipe (
  issue_if.consumer                    issue_i,
  output logic [calc_pkg::DWORD_W-1:0] alu_data_o
);
  import calc_pkg::*;

  // Result is captured by completion stage 1
  always_comb
  begin
    case (issue_i.op)
      OP_ADD:  alu_data_o = issue_i.opnd_a + issue_i.opnd_b;
      OP_SUB:  alu_data_o = issue_i.opnd_a - issue_i.opnd_b;
      OP_AND:  alu_data_o = issue_i.opnd_a & issue_i.opnd_b;
      OP_OR:   alu_data_o = issue_i.opnd_a | issue_i.opnd_b;
      OP_XOR:  alu_data_o = issue_i.opnd_a ^ issue_i.opnd_b;
      // MUL result arrives later from the multiply pipe
      default: alu_data_o = '0;
    endcase
  end

endmodule

// ==== design/mul_pipe.sv ====
/*
 * Multiply pipe
 * Registers the two operands of an issued MUL and forms the low 64 bits
 * of the product for completion stage 2
 */
`timescale 1ns/1ps

module mul_pipe (
  input  logic                         clk_i,
  issue_if.consumer                    issue_i,
  output logic [calc_pkg::DWORD_W-1:0] mul_data_o
);
  import calc_pkg::*;

  logic               mul_en;
  logic [DWORD_W-1:0] mul_a_r;
  logic [DWORD_W-1:0] mul_b_r;

  // Load only on a MUL so the registers idle otherwise
  assign mul_en = issue_i.v && (issue_i.op == OP_MUL);

  // A new MUL may load every cycle
  always_ff @(posedge clk_i)
  begin
    if (mul_en)
    begin
      mul_a_r <= issue_i.opnd_a;
      mul_b_r <= issue_i.opnd_b;
    end
  end

  // Low half only, context width truncates
  assign mul_data_o = mul_a_r * mul_b_r;

endmodule

// ==== design/completion_pipe.sv ====
/*
 * Completion pipe
 * Carries each issued instruction through the result stages with its
 * poison bit and provides forwarding, commit and writeback
 */
`timescale 1ns/1ps

module completion_pipe (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic                                                  flush_i,
  issue_if.consumer                                             issue_i,
  input  logic [calc_pkg::INSTR_W-1:0]                          issue_instr_i,
  input  logic [calc_pkg::DWORD_W-1:0]                          alu_data_i,
  input  logic [calc_pkg::DWORD_W-1:0]                          mul_data_i,
  output logic [calc_pkg::WB_STAGE:1]                           fwd_v_o,
  output logic [calc_pkg::WB_STAGE:1][calc_pkg::REG_ADDR_W-1:0] fwd_rd_addr_o,
  output logic [calc_pkg::WB_STAGE:1][calc_pkg::DWORD_W-1:0]    fwd_data_o,
  output logic                                                  commit_v_o,
  output logic [calc_pkg::INSTR_W-1:0]                          commit_instr_o,
  output logic                                                  wb_v_o,
  output logic [calc_pkg::REG_ADDR_W-1:0]                       wb_rd_addr_o,
  output logic [calc_pkg::DWORD_W-1:0]                          wb_data_o
);
  import calc_pkg::*;

  logic [WB_STAGE:1]                 v_r;
  logic [WB_STAGE:1]                 v_n;
  logic [WB_STAGE:1]                 poison_r;
  logic [WB_STAGE:1]                 poison_n;
  logic [WB_STAGE:1]                 wr_r;
  logic [WB_STAGE:1]                 wr_n;
  logic [WB_STAGE:1]                 mul_r;
  logic [WB_STAGE:1]                 mul_n;
  logic [WB_STAGE:1][REG_ADDR_W-1:0] rd_r;
  logic [WB_STAGE:1][REG_ADDR_W-1:0] rd_n;
  logic [WB_STAGE:1][INSTR_W-1:0]    instr_r;
  logic [WB_STAGE:1][INSTR_W-1:0]    instr_n;
  logic [WB_STAGE:1][DWORD_W-1:0]    data_r;
  logic [WB_STAGE:1][DWORD_W-1:0]    data_n;

  always_comb
  begin
    // Stage 1 takes the issued operation
    v_n[1]      = issue_i.v;
    wr_n[1]     = issue_i.wr_v;
    rd_n[1]     = issue_i.rd_addr;
    instr_n[1]  = issue_instr_i;
    mul_n[1]    = (issue_i.op == OP_MUL);
    poison_n[1] = flush_i;
    data_n[1]   = '0;
    for (int i = 2; i <= WB_STAGE; i++)
    begin
      v_n[i]      = v_r[i-1];
      wr_n[i]     = wr_r[i-1];
      rd_n[i]     = rd_r[i-1];
      instr_n[i]  = instr_r[i-1];
      mul_n[i]    = mul_r[i-1];
      // Nothing past the commit stage can be flushed
      poison_n[i] = poison_r[i-1] | (flush_i & (i <= COMMIT_STAGE));
      data_n[i]   = data_r[i-1];
    end
    // Each pipe drops its result in where it finishes
    data_n[ALU_STAGE] = alu_data_i;
    if (mul_r[MUL_STAGE-1])
    begin
      data_n[MUL_STAGE] = mul_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r      <= '0;
      poison_r <= '0;
    end
    else
    begin
      v_r      <= v_n;
      poison_r <= poison_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    wr_r    <= wr_n;
    mul_r   <= mul_n;
    rd_r    <= rd_n;
    instr_r <= instr_n;
    data_r  <= data_n;
  end

  // Taps show next-state values of live writers only
  assign fwd_v_o       = v_n & wr_n & ~poison_n;
  assign fwd_rd_addr_o = rd_n;
  assign fwd_data_o    = data_n;

  assign commit_v_o     = v_r[COMMIT_STAGE] & ~poison_r[COMMIT_STAGE];
  assign commit_instr_o = instr_r[COMMIT_STAGE];

  assign wb_v_o       = v_r[WB_STAGE] & wr_r[WB_STAGE] & ~poison_r[WB_STAGE];
  assign wb_rd_addr_o = rd_r[WB_STAGE];
  assign wb_data_o    = data_r[WB_STAGE];

endmodule

// ==== design/bp_calculator_top.sv ====
/*
 * Integer execution calculator
 * Issue stage with operand bypass, ALU and multiply pipes, and the
 * completion pipe that drives commit and writeback
 */
`timescale 1ns/1ps

module bp_calculator_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            dispatch_v_i,
  input  logic [calc_pkg::INSTR_W-1:0]    instr_i,
  input  logic [calc_pkg::DWORD_W-1:0]    rs1_i,
  input  logic [calc_pkg::DWORD_W-1:0]    rs2_i,
  input  logic                            flush_i,
  output logic                            commit_v_o,
  output logic [calc_pkg::INSTR_W-1:0]    commit_instr_o,
  output logic                            wb_v_o,
  output logic [calc_pkg::REG_ADDR_W-1:0] wb_rd_addr_o,
  output logic [calc_pkg::DWORD_W-1:0]    wb_data_o
);
  import calc_pkg::*;

  logic [INSTR_W-1:0]                issue_instr;
  logic [DWORD_W-1:0]                alu_data;
  logic [DWORD_W-1:0]                mul_data;
  // Forwarding taps from the completion pipe
  logic [WB_STAGE:1]                 fwd_v;
  logic [WB_STAGE:1][REG_ADDR_W-1:0] fwd_rd_addr;
  logic [WB_STAGE:1][DWORD_W-1:0]    fwd_data;

  issue_if issue_bus ();

  issue_stage i_issue_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dispatch_v_i  (dispatch_v_i),
    .instr_i       (instr_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .flush_i       (flush_i),
    .fwd_v_i       (fwd_v),
    .fwd_rd_addr_i (fwd_rd_addr),
    .fwd_data_i    (fwd_data),
    .issue_o       (issue_bus.producer),
    .issue_instr_o (issue_instr)
  );

  int_alu_pipe i_int_alu_pipe (
    .issue_i    (issue_bus.consumer),
    .alu_data_o (alu_data)
  );

  mul_pipe i_mul_pipe (
    .clk_i      (clk_i),
    .issue_i    (issue_bus.consumer),
    .mul_data_o (mul_data)
  );

  completion_pipe i_completion_pipe (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .issue_i        (issue_bus.consumer),
    .issue_instr_i  (issue_instr),
    .alu_data_i     (alu_data),
    .mul_data_i     (mul_data),
    .fwd_v_o        (fwd_v),
    .fwd_rd_addr_o  (fwd_rd_addr),
    .fwd_data_o     (fwd_data),
    .commit_v_o     (commit_v_o),
    .commit_instr_o (commit_instr_o),
    .wb_v_o         (wb_v_o),
    .wb_rd_addr_o   (wb_rd_addr_o),
    .wb_data_o      (wb_data_o)
  );

endmodule

// ==== dv/calc_properties.sv ====
/*
 * Calculator timing properties
 * Commit to writeback spacing, flush quiet time and the MUL read rule
 */
`timescale 1ns/1ps

module calc_properties (
  input logic                            clk_i,
  input logic                            rst_i,
  input logic                            dispatch_v_i,
  input logic [calc_pkg::INSTR_W-1:0]    instr_i,
  input logic                            flush_i,
  input logic                            commit_v_i,
  input logic [calc_pkg::INSTR_W-1:0]    commit_instr_i,
  input logic                            wb_v_i,
  input logic [calc_pkg::REG_ADDR_W-1:0] wb_rd_addr_i
);
  import calc_pkg::*;

  int prop_errors = 0;

  // Supported integer operation with a destination other than x0
  function automatic logic writes_reg(input logic [INSTR_W-1:0] w);
    logic ok;
    ok = 1'b0;
    if (w[6:0] == OPC_OP)
    begin
      ok = (w[14:12] == 3'b000 && w[31:25] inside {7'h00, 7'h20, FUNCT7_MULDIV}) ||
           (w[31:25] == 7'h00 && w[14:12] inside {3'b100, 3'b110, 3'b111});
    end
    else if (w[6:0] == OPC_OP_IMM)
    begin
      ok = w[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111};
    end
    return ok && (w[11:7] != '0);
  endfunction

  function automatic logic is_mul(input logic [INSTR_W-1:0] w);
    return (w[6:0] == OPC_OP) && (w[31:25] == FUNCT7_MULDIV) && (w[14:12] == 3'b000);
  endfunction

  // rs2 only counts for the register-register form
  function automatic logic reads_reg(input logic [INSTR_W-1:0] w,
                                     input logic [REG_ADDR_W-1:0] r);
    if (r == '0)
    begin
      return 1'b0;
    end
    return (w[19:15] == r) || ((w[6:0] == OPC_OP) && (w[24:20] == r));
  endfunction

  commit_then_wb: assert property (@(posedge clk_i) disable iff (rst_i)
    (commit_v_i && writes_reg(commit_instr_i)) |=> wb_v_i)
  else
  begin
    prop_errors++;
    $error("writeback missing one cycle after a writing commit");
  end

  wb_after_commit: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_v_i |-> $past(commit_v_i))
  else
  begin
    prop_errors++;
    $error("writeback without a commit in the cycle before");
  end

  wb_not_x0: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_v_i |-> (wb_rd_addr_i != '0))
  else
  begin
    prop_errors++;
    $error("writeback to x0");
  end

  // The instruction three dispatches back still retires right after the flush
  flush_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |-> ##2 !wb_v_i ##1 !wb_v_i ##1 !wb_v_i)
  else
  begin
    prop_errors++;
    $error("writeback of a flushed instruction");
  end

  mul_read_rule: assert property (@(posedge clk_i) disable iff (rst_i)
    (dispatch_v_i && $past(dispatch_v_i) && is_mul($past(instr_i)))
      |-> !reads_reg(instr_i, $past(instr_i[11:7])))
  else
  begin
    prop_errors++;
    $error("instruction reads the destination of the MUL just before it");
  end

endmodule

bind bp_calculator_top calc_properties i_calc_properties (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .dispatch_v_i   (dispatch_v_i),
  .instr_i        (instr_i),
  .flush_i        (flush_i),
  .commit_v_i     (commit_v_o),
  .commit_instr_i (commit_instr_o),
  .wb_v_i         (wb_v_o),
  .wb_rd_addr_i   (wb_rd_addr_o)
);

// ==== dv/calc_tb.sv ====
/*
 * Testbench for the integer execution calculator
 * Dispatches directed and random operations with stale operands and
 * flushes, and checks commit and writeback against a register model
 */
`timescale 1ns/1ps

module calc_tb;
  import calc_pkg::*;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [DWORD_W-1:0]    data;
  } wb_exp_t;

  // One record per dispatch cycle that a flush can undo
  typedef struct packed {
    logic                  has_wb;
    logic                  has_commit;
    logic [REG_ADDR_W-1:0] rd;
    logic [DWORD_W-1:0]    old;
  } cycle_rec_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  dispatch_v;
  logic [INSTR_W-1:0]    instr;
  logic [DWORD_W-1:0]    rs1;
  logic [DWORD_W-1:0]    rs2;
  logic                  flush;
  logic                  commit_v;
  logic [INSTR_W-1:0]    commit_instr;
  logic                  wb_v;
  logic [REG_ADDR_W-1:0] wb_rd_addr;
  logic [DWORD_W-1:0]    wb_data;

  // Registers in dispatch order, and the copy written at writeback
  logic [DWORD_W-1:0]    arch_regs [32];
  logic [DWORD_W-1:0]    stale_regs [32];
  wb_exp_t               wb_q [$];
  logic [INSTR_W-1:0]    commit_q [$];
  cycle_rec_t            recent_q [$];
  logic [REG_ADDR_W-1:0] prev_mul_rd;
  integer                seed;
  int                    errors;

  always #50 clk = ~clk;

  bp_calculator_top i_bp_calculator_top (
    .clk_i          (clk),
    .rst_i          (rst),
    .dispatch_v_i   (dispatch_v),
    .instr_i        (instr),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .flush_i        (flush),
    .commit_v_o     (commit_v),
    .commit_instr_o (commit_instr),
    .wb_v_o         (wb_v),
    .wb_rd_addr_o   (wb_rd_addr),
    .wb_data_o      (wb_data)
  );

  function automatic logic [INSTR_W-1:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb);
    return {f7, rb, ra, f3, rd, OPC_OP};
  endfunction

  function automatic logic [INSTR_W-1:0] itype(input logic [2:0] f3, input logic [4:0] rd,
      input logic [4:0] ra, input logic [11:0] imm);
    return {imm, ra, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic is_mul(input logic [INSTR_W-1:0] w);
    return (w[6:0] == OPC_OP) && (w[31:25] == FUNCT7_MULDIV) && (w[14:12] == 3'b000);
  endfunction

  // MUL result is not ready for the very next dispatch
  function automatic logic reads_mul_dest(input logic [INSTR_W-1:0] w);
    return (prev_mul_rd != '0) &&
           ((w[19:15] == prev_mul_rd) || ((w[6:0] == OPC_OP) && (w[24:20] == prev_mul_rd)));
  endfunction

  // Random registers stay within x0 to x7 so dependencies are dense
  function automatic logic [INSTR_W-1:0] random_instr();
    int unsigned kind;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [11:0] imm;
    kind = $unsigned($random(seed)) % 10;
    rd   = $unsigned($random(seed)) % 8;
    ra   = $unsigned($random(seed)) % 8;
    rb   = $unsigned($random(seed)) % 8;
    imm  = $random(seed);
    case (kind)
      0:       return rtype(7'h00, 3'b000, rd, ra, rb);
      1:       return rtype(7'h20, 3'b000, rd, ra, rb);
      2:       return rtype(7'h00, 3'b100, rd, ra, rb);
      3:       return rtype(7'h00, 3'b110, rd, ra, rb);
      4:       return rtype(7'h00, 3'b111, rd, ra, rb);
      5:       return rtype(FUNCT7_MULDIV, 3'b000, rd, ra, rb);
      6:       return itype(3'b000, rd, ra, imm);
      7:       return itype(3'b100, rd, ra, imm);
      8:       return itype(3'b110, rd, ra, imm);
      default: return itype(3'b111, rd, ra, imm);
    endcase
  endfunction

  // RV64I and RV64M semantics on the model registers
  task automatic ref_result(input logic [INSTR_W-1:0] w, output logic writes,
                            output logic [DWORD_W-1:0] res);
    logic [DWORD_W-1:0] a;
    logic [DWORD_W-1:0] b;
    a      = arch_regs[w[19:15]];
    b      = (w[6:0] == OPC_OP_IMM) ? {{52{w[31]}}, w[31:20]} : arch_regs[w[24:20]];
    writes = 1'b1;
    res    = '0;
    if (w[6:0] == OPC_OP && w[31:25] == 7'h01 && w[14:12] == 3'b000)
    begin
      res = a * b;
    end
    else if (w[6:0] == OPC_OP && w[31:25] == 7'h20 && w[14:12] == 3'b000)
    begin
      res = a - b;
    end
    else if (w[6:0] == OPC_OP_IMM || (w[6:0] == OPC_OP && w[31:25] == 7'h00))
    begin
      case (w[14:12])
        3'b000:  res = a + b;
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: writes = 1'b0;
      endcase
    end
    else
    begin
      writes = 1'b0;
    end
    if (w[11:7] == '0)
    begin
      writes = 1'b0;
    end
  endtask

  task automatic value_error(input string name, input logic [DWORD_W-1:0] exp_val,
                             input logic [DWORD_W-1:0] act_val);
    errors++;
    $display("ERR %0t %s expected %h actual %h", $time, name, exp_val, act_val);
  endtask

  // Outputs settle just after the rising edge
  task automatic observe_outputs();
    wb_exp_t e;
    @(posedge clk);
    #1;
    assert (!$isunknown({commit_v, wb_v}))
    else
    begin
      errors++;
      $display("Commit or writeback valid is unknown at %0t", $time);
    end
    if (commit_v === 1'b1)
    begin
      assert (commit_q.size() != 0)
      else
      begin
        errors++;
        $display("Commit at %0t while no instruction was expected to commit", $time);
      end
      if (commit_q.size() != 0)
      begin
        assert (commit_instr === commit_q[0])
        else value_error("commit_instr_o", commit_q[0], commit_instr);
        void'(commit_q.pop_front());
      end
    end
    if (wb_v === 1'b1)
    begin
      assert (wb_q.size() != 0)
      else
      begin
        errors++;
        $display("Writeback at %0t while no writeback was expected", $time);
      end
      if (wb_q.size() != 0)
      begin
        e = wb_q.pop_front();
        assert (wb_rd_addr === e.rd)
        else value_error("wb_rd_addr_o", e.rd, wb_rd_addr);
        assert (wb_data === e.data)
        else value_error("wb_data_o", e.data, wb_data);
        // The dispatch in this cycle already sees the written register
        stale_regs[e.rd] = e.data;
      end
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic [INSTR_W-1:0] w,
                             input logic do_flush);
    cycle_rec_t         rec;
    wb_exp_t            e;
    logic               writes;
    logic [DWORD_W-1:0] res;
    observe_outputs();
    dispatch_v = valid;
    instr      = w;
    rs1        = stale_regs[w[19:15]];
    rs2        = stale_regs[w[24:20]];
    flush      = do_flush;
    rec        = '0;
    if (valid)
    begin
      ref_result(w, writes, res);
      commit_q.push_back(w);
      rec.has_commit = 1'b1;
      if (writes)
      begin
        rec.has_wb          = 1'b1;
        rec.rd              = w[11:7];
        rec.old             = arch_regs[w[11:7]];
        arch_regs[w[11:7]]  = res;
        e.rd                = w[11:7];
        e.data              = res;
        wb_q.push_back(e);
      end
    end
    recent_q.push_back(rec);
    if (recent_q.size() > 3)
      void'(recent_q.pop_front());
    // Flush cancels this cycle and the two before it
    if (do_flush)
    begin
      while (recent_q.size() != 0)
      begin
        rec = recent_q.pop_back();
        if (rec.has_wb)
        begin
          arch_regs[rec.rd] = rec.old;
          void'(wb_q.pop_back());
        end
        if (rec.has_commit)
          void'(commit_q.pop_back());
      end
    end
    prev_mul_rd = (valid && is_mul(w)) ? w[11:7] : '0;
  endtask

  task automatic dispatch(input logic [INSTR_W-1:0] w);
    drive_cycle(1'b1, w, 1'b0);
  endtask

  initial
  begin
    logic [INSTR_W-1:0] w;
    int unsigned        roll;
    int                 prop_errs;
    seed        = 32'h6cd5_6da6;
    errors      = 0;
    prev_mul_rd = '0;
    rst         = 1'b1;
    dispatch_v  = 1'b0;
    instr       = '0;
    rs1         = '0;
    rs2         = '0;
    flush       = 1'b0;
    for (int r = 0; r < 32; r++)
    begin
      arch_regs[r]  = {$random(seed), $random(seed)};
      stale_regs[r] = arch_regs[r];
    end
    // x0 is driven with garbage and must still read as zero
    arch_regs[0] = '0;
    repeat (10) observe_outputs();
    rst = 1'b0;

    // Chains at distances 1 to 4 through the bypass
    dispatch(itype(3'b000, 5'd1, 5'd0, 12'h7ff));
    dispatch(rtype(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
    dispatch(rtype(7'h20, 3'b000, 5'd3, 5'd2, 5'd1));
    dispatch(rtype(7'h00, 3'b100, 5'd4, 5'd3, 5'd1));
    dispatch(rtype(7'h00, 3'b110, 5'd5, 5'd1, 5'd4));
    dispatch(itype(3'b111, 5'd6, 5'd5, 12'h8f0));
    // MUL consumers at distance 2 and 3
    dispatch(rtype(FUNCT7_MULDIV, 3'b000, 5'd7, 5'd5, 5'd6));
    dispatch(itype(3'b000, 5'd8, 5'd1, 12'h001));
    dispatch(rtype(7'h00, 3'b000, 5'd9, 5'd7, 5'd7));
    dispatch(rtype(FUNCT7_MULDIV, 3'b000, 5'd10, 5'd7, 5'd9));
    dispatch(itype(3'b100, 5'd11, 5'd2, 12'h5a5));
    dispatch(rtype(FUNCT7_MULDIV, 3'b000, 5'd12, 5'd10, 5'd10));
    // Writes to x0 and a read of x0
    dispatch(rtype(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
    dispatch(itype(3'b000, 5'd0, 5'd3, 12'h055));
    dispatch(rtype(7'h00, 3'b111, 5'd13, 5'd0, 5'd12));
    // Load opcode is not supported and commits without a writeback
    dispatch({12'h000, 5'd1, 3'b011, 5'd14, 7'b0000011});
    // Flush takes out the last three dispatches
    dispatch(itype(3'b000, 5'd15, 5'd0, 12'h111));
    dispatch(itype(3'b000, 5'd16, 5'd0, 12'h222));
    dispatch(itype(3'b000, 5'd17, 5'd0, 12'h333));
    drive_cycle(1'b1, itype(3'b000, 5'd15, 5'd16, 12'h444), 1'b1);
    dispatch(rtype(7'h00, 3'b000, 5'd18, 5'd15, 5'd16));
    dispatch(rtype(7'h00, 3'b110, 5'd19, 5'd17, 5'd18));

    for (int n = 0; n < 300; n++)
    begin
      w    = random_instr();
      roll = $unsigned($random(seed)) % 16;
      if (roll == 0 || reads_mul_dest(w))
        drive_cycle(1'b0, w, 1'b0);
      else
        drive_cycle(1'b1, w, roll == 1);
    end

    for (int n = 0; n < 10 && (wb_q.size() != 0 || commit_q.size() != 0); n++)
      drive_cycle(1'b0, '0, 1'b0);
    if (wb_q.size() != 0 || commit_q.size() != 0)
    begin
      errors++;
      $display("Timeout: %0d writebacks and %0d commits never appeared",
               wb_q.size(), commit_q.size());
    end

    prop_errs = i_bp_calculator_top.i_calc_properties.prop_errors;
    $display("Errors: %0d check failures, %0d property failures", errors, prop_errs);
    if (errors == 0 && prop_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
design/calc_pkg.sv
design/issue_if.sv
design/issue_stage.sv
design/int_alu_pipe.sv
design/mul_pipe.sv
design/completion_pipe.sv
design/bp_calculator_top.sv
dv/calc_properties.sv
dv/calc_tb.sv

// ==== Bender.yml ====
package:
  name: bp_calculator

sources:
  - files:
      - design/calc_pkg.sv
      - design/issue_if.sv
      - design/issue_stage.sv
      - design/int_alu_pipe.sv
      - design/mul_pipe.sv
      - design/completion_pipe.sv
      - design/bp_calculator_top.sv
  - target: test
    files:
      - dv/calc_properties.sv
      - dv/calc_tb.sv
